//--- wired_pkg.sv
package wired_pkg;

    // 32-bit datapath word, used for operands, pc and results
    typedef logic [31:0] word_t;

    // rob index, doubles as destination and source tag
    typedef logic [5:0] rob_rid_t;

    // alu operation selector
    typedef logic [3:0] alu_op_t;

    // alu op codes
    localparam alu_op_t ALU_ADD   = 4'd0;
    localparam alu_op_t ALU_SUB   = 4'd1;
    localparam alu_op_t ALU_AND   = 4'd2;
    localparam alu_op_t ALU_OR    = 4'd3;
    localparam alu_op_t ALU_XOR   = 4'd4;
    // shifts take the amount from the low five bits of r1
    localparam alu_op_t ALU_SLL   = 4'd5;
    localparam alu_op_t ALU_SRL   = 4'd6;
    localparam alu_op_t ALU_SRA   = 4'd7;
    // set-less-than, signed and unsigned
    localparam alu_op_t ALU_SLT   = 4'd8;
    localparam alu_op_t ALU_SLTU  = 4'd9;
    // pc relative add, pc + r1
    localparam alu_op_t ALU_PCADD = 4'd10;
    // codes 11..15 are unused and give zero

    // issue queue slots
    localparam int IQ_DEPTH    = 8;
    // empty slot counter width
    localparam int IQ_CNT_W    = $clog2(IQ_DEPTH + 1);

    // per-lane result fifo toward the cdb
    localparam int FIFO_DEPTH  = 4;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);

    // snooped broadcast ports
    localparam int CDB_PORTS   = 2;

    // dispatch and issue lanes
    localparam int ISSUE_WIDTH = 2;

endpackage

//--- wired_alu.sv
`timescale 1ns/1ps

module wired_alu (
    input  wired_pkg::word_t   r0_i,
    input  wired_pkg::word_t   r1_i,
    input  wired_pkg::word_t   pc_i,
    input  wired_pkg::alu_op_t op_i,
    output wired_pkg::word_t   res_o
);
    import wired_pkg::*;

    // shift amount, low five bits of the second operand
    logic [4:0] shamt;

    // signed views for slt and sra
    logic signed [31:0] r0_s;
    logic signed [31:0] r1_s;

    assign shamt = r1_i[4:0];
    assign r0_s  = $signed(r0_i);
    assign r1_s  = $signed(r1_i);

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                res_o = r0_i + r1_i;
            end
            ALU_SUB: begin
                res_o = r0_i - r1_i;
            end
            ALU_AND: begin
                res_o = r0_i & r1_i;
            end
            ALU_OR: begin
                res_o = r0_i | r1_i;
            end
            ALU_XOR: begin
                res_o = r0_i ^ r1_i;
            end
            ALU_SLL: begin
                res_o = r0_i << shamt;
            end
            ALU_SRL: begin
                res_o = r0_i >> shamt;
            end
            ALU_SRA: begin
                // sign bit fills from the left
                res_o = r0_s >>> shamt;
            end
            ALU_SLT: begin
                res_o = {31'b0, r0_s < r1_s};
            end
            ALU_SLTU: begin
                res_o = {31'b0, r0_i < r1_i};
            end
            ALU_PCADD: begin
                // auipc style, pc plus immediate in r1
                res_o = pc_i + r1_i;
            end
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

//--- wired_iq_entry.sv
`timescale 1ns/1ps

module wired_iq_entry (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                alloc_i,
    input  logic                issue_i,
    input  wired_pkg::rob_rid_t rid_i,
    input  wired_pkg::alu_op_t  op_i,
    input  wired_pkg::word_t    pc_i,
    input  logic [1:0]          src_valid_i,
    input  wired_pkg::rob_rid_t src_tag_i [2],
    input  wired_pkg::word_t    src_data_i [2],
    input  logic [wired_pkg::CDB_PORTS-1:0] cdb_valid_i,
    input  wired_pkg::rob_rid_t cdb_rid_i [wired_pkg::CDB_PORTS],
    input  wired_pkg::word_t    cdb_data_i [wired_pkg::CDB_PORTS],
    output logic                busy_o,
    output logic                ready_o,
    output wired_pkg::rob_rid_t rid_o,
    output wired_pkg::alu_op_t  op_o,
    output wired_pkg::word_t    pc_o,
    output wired_pkg::word_t    data_o [2]
);
    import wired_pkg::*;

    logic       busy_q;
    logic       ready_q;
    logic [1:0] src_valid_q;
    rob_rid_t   src_tag_q [2];
    word_t      src_data_q [2];
    rob_rid_t   rid_q;
    alu_op_t    op_q;
    word_t      pc_q;

    // snoop compare tag, incoming on alloc else the stored one
    rob_rid_t   tag_cmp [2];
    logic [1:0] hit;
    word_t      hit_data [2];

    logic       busy_n;
    logic [1:0] src_valid_n;
    word_t      src_data_n [2];

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            tag_cmp[k]  = alloc_i ? src_tag_i[k] : src_tag_q[k];
            hit[k]      = 1'b0;
            hit_data[k] = '0;
            for (int c = 0; c < CDB_PORTS; c++) begin
                if (cdb_valid_i[c] && cdb_rid_i[c] == tag_cmp[k]) begin
                    hit[k]      = 1'b1;
                    hit_data[k] = cdb_data_i[c];
                end
            end
            src_valid_n[k] = src_valid_q[k];
            src_data_n[k]  = src_data_q[k];
            if (alloc_i) begin
                // operand given at dispatch wins over a broadcast
                src_valid_n[k] = src_valid_i[k] | hit[k];
                src_data_n[k]  = src_valid_i[k] ? src_data_i[k] : hit_data[k];
            end else if (!src_valid_q[k] && hit[k]) begin
                src_valid_n[k] = 1'b1;
                src_data_n[k]  = hit_data[k];
            end
        end
        // flush drops a same-cycle dispatch too
        if (flush_i) begin
            busy_n = 1'b0;
        end else if (alloc_i) begin
            busy_n = 1'b1;
        end else if (issue_i) begin
            busy_n = 1'b0;
        end else begin
            busy_n = busy_q;
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q      <= 1'b0;
            ready_q     <= 1'b0;
            src_valid_q <= '0;
        end else begin
            busy_q      <= busy_n;
            ready_q     <= busy_n & (&src_valid_n);
            src_valid_q <= src_valid_n;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rid_q <= rid_i;
            op_q  <= op_i;
            pc_q  <= pc_i;
        end
        for (int k = 0; k < 2; k++) begin
            if (alloc_i) begin
                src_tag_q[k] <= src_tag_i[k];
            end
            src_data_q[k] <= src_data_n[k];
        end
    end

    assign busy_o  = busy_q;
    assign ready_o = ready_q;
    assign rid_o   = rid_q;
    assign op_o    = op_q;
    assign pc_o    = pc_q;
    assign data_o  = src_data_q;

endmodule

//--- wired_cdb_fifo.sv
`timescale 1ns/1ps

module wired_cdb_fifo (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                push_i,
    input  wired_pkg::rob_rid_t push_rid_i,
    input  wired_pkg::word_t    push_data_i,
    input  logic                pop_ready_i,
    output logic                full_o,
    output logic                valid_o,
    output wired_pkg::rob_rid_t rid_o,
    output wired_pkg::word_t    data_o
);
    import wired_pkg::*;

    // result storage
    rob_rid_t rid_mem [FIFO_DEPTH];
    word_t    data_mem [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_CNT_W-1:0] count_q;

    logic do_push;
    logic do_pop;

    assign full_o  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
    assign valid_o = (count_q != '0);
    // push while full is ignored, issue is stalled upstream anyway
    assign do_push = push_i & ~full_o;
    assign do_pop  = valid_o & pop_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            rid_mem[wr_ptr_q]  <= push_rid_i;
            data_mem[wr_ptr_q] <= push_data_i;
        end
    end

    // head shows straight from storage
    assign rid_o  = rid_mem[rd_ptr_q];
    assign data_o = data_mem[rd_ptr_q];

endmodule

//--- wired_alu_iq.sv
`timescale 1ns/1ps

module wired_alu_iq (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic [wired_pkg::ISSUE_WIDTH-1:0] p_valid_i,
    input  wired_pkg::rob_rid_t p_rid_i [wired_pkg::ISSUE_WIDTH],
    input  wired_pkg::alu_op_t  p_op_i [wired_pkg::ISSUE_WIDTH],
    input  wired_pkg::word_t    p_pc_i [wired_pkg::ISSUE_WIDTH],
    input  logic [1:0]          p_src_valid_i [wired_pkg::ISSUE_WIDTH],
    input  wired_pkg::rob_rid_t p_src_tag_i [wired_pkg::ISSUE_WIDTH][2],
    input  wired_pkg::word_t    p_src_data_i [wired_pkg::ISSUE_WIDTH][2],
    output logic                p_ready_o,
    input  logic [wired_pkg::CDB_PORTS-1:0] cdb_valid_i,
    input  wired_pkg::rob_rid_t cdb_rid_i [wired_pkg::CDB_PORTS],
    input  wired_pkg::word_t    cdb_data_i [wired_pkg::CDB_PORTS],
    input  logic                fu_stall_i,
    output logic [wired_pkg::ISSUE_WIDTH-1:0] iss_valid_o,
    output wired_pkg::rob_rid_t iss_rid_o [wired_pkg::ISSUE_WIDTH],
    output wired_pkg::word_t    iss_res_o [wired_pkg::ISSUE_WIDTH]
);
    import wired_pkg::*;

    // one-hot of the lowest set bit
    function automatic logic [IQ_DEPTH-1:0] first_one(input logic [IQ_DEPTH-1:0] vec);
        logic [IQ_DEPTH-1:0] sel;
        sel = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                sel    = '0;
                sel[i] = 1'b1;
            end
        end
        return sel;
    endfunction

    // one-hot of the highest set bit
    function automatic logic [IQ_DEPTH-1:0] last_one(input logic [IQ_DEPTH-1:0] vec);
        logic [IQ_DEPTH-1:0] sel;
        sel = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (vec[i]) begin
                sel    = '0;
                sel[i] = 1'b1;
            end
        end
        return sel;
    endfunction

    logic [IQ_DEPTH-1:0] ent_busy;
    logic [IQ_DEPTH-1:0] ent_ready;
    rob_rid_t            ent_rid [IQ_DEPTH];
    alu_op_t             ent_op [IQ_DEPTH];
    word_t               ent_pc [IQ_DEPTH];
    word_t               ent_data [IQ_DEPTH][2];

    logic [IQ_DEPTH-1:0] empty_lo;
    logic [IQ_DEPTH-1:0] empty_hi;
    logic [IQ_CNT_W-1:0] empty_cnt;
    logic [IQ_DEPTH-1:0] alloc;
    logic [IQ_DEPTH-1:0] issue;
    logic [IQ_DEPTH-1:0] iss_sel [ISSUE_WIDTH];

    // alu operand muxes per lane
    word_t   alu_r0 [ISSUE_WIDTH];
    word_t   alu_r1 [ISSUE_WIDTH];
    word_t   alu_pc [ISSUE_WIDTH];
    alu_op_t alu_op [ISSUE_WIDTH];

    // lane 0 fills from the bottom, lane 1 from the top
    assign empty_lo = first_one(~ent_busy);
    assign empty_hi = last_one(~ent_busy);

    always_comb begin
        empty_cnt = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (!ent_busy[i]) begin
                empty_cnt = empty_cnt + 1'b1;
            end
        end
    end

    // two free slots needed so both lanes always fit
    assign p_ready_o = (empty_cnt >= IQ_CNT_W'(2));
    assign alloc = {IQ_DEPTH{~flush_i & p_ready_o}} &
                   ((empty_lo & {IQ_DEPTH{p_valid_i[0]}}) | (empty_hi & {IQ_DEPTH{p_valid_i[1]}}));

    // select from both ends, single issue if they meet
    assign iss_sel[0]     = first_one(ent_ready);
    assign iss_sel[1]     = last_one(ent_ready);
    assign iss_valid_o[0] = (|ent_ready) & ~fu_stall_i & ~flush_i;
    assign iss_valid_o[1] = iss_valid_o[0] & (iss_sel[0] != iss_sel[1]);
    assign issue = (iss_sel[0] & {IQ_DEPTH{iss_valid_o[0]}}) |
                   (iss_sel[1] & {IQ_DEPTH{iss_valid_o[1]}});

    for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_entry
        logic       take_hi;
        logic [1:0] in_src_valid;
        rob_rid_t   in_src_tag [2];
        word_t      in_src_data [2];

        // slot owned by lane 1 when it is the top free one
        assign take_hi = p_valid_i[1] & empty_hi[i];

        always_comb begin
            for (int k = 0; k < 2; k++) begin
                in_src_valid[k] = take_hi ? p_src_valid_i[1][k] : p_src_valid_i[0][k];
                in_src_tag[k]   = take_hi ? p_src_tag_i[1][k] : p_src_tag_i[0][k];
                in_src_data[k]  = take_hi ? p_src_data_i[1][k] : p_src_data_i[0][k];
            end
        end

        wired_iq_entry wired_iq_entry_i (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .alloc_i     (alloc[i]),
            .issue_i     (issue[i]),
            .rid_i       (take_hi ? p_rid_i[1] : p_rid_i[0]),
            .op_i        (take_hi ? p_op_i[1] : p_op_i[0]),
            .pc_i        (take_hi ? p_pc_i[1] : p_pc_i[0]),
            .src_valid_i (in_src_valid),
            .src_tag_i   (in_src_tag),
            .src_data_i  (in_src_data),
            .cdb_valid_i (cdb_valid_i),
            .cdb_rid_i   (cdb_rid_i),
            .cdb_data_i  (cdb_data_i),
            .busy_o      (ent_busy[i]),
            .ready_o     (ent_ready[i]),
            .rid_o       (ent_rid[i]),
            .op_o        (ent_op[i]),
            .pc_o        (ent_pc[i]),
            .data_o      (ent_data[i])
        );
    end

    // and-or style operand mux
    always_comb begin
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            alu_r0[l]    = '0;
            alu_r1[l]    = '0;
            alu_pc[l]    = '0;
            alu_op[l]    = '0;
            iss_rid_o[l] = '0;
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (iss_sel[l][i]) begin
                    alu_r0[l]    = ent_data[i][0];
                    alu_r1[l]    = ent_data[i][1];
                    alu_pc[l]    = ent_pc[i];
                    alu_op[l]    = ent_op[i];
                    iss_rid_o[l] = ent_rid[i];
                end
            end
        end
    end

    for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_alu
        wired_alu wired_alu_i (
            .r0_i  (alu_r0[l]),
            .r1_i  (alu_r1[l]),
            .pc_i  (alu_pc[l]),
            .op_i  (alu_op[l]),
            .res_o (iss_res_o[l])
        );
    end

endmodule

//--- wired_alu_cluster.sv
`timescale 1ns/1ps

module wired_alu_cluster (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic [wired_pkg::ISSUE_WIDTH-1:0] p_valid_i,
    input  wired_pkg::rob_rid_t p_rid_i [wired_pkg::ISSUE_WIDTH],
    input  wired_pkg::alu_op_t  p_op_i [wired_pkg::ISSUE_WIDTH],
    input  wired_pkg::word_t    p_pc_i [wired_pkg::ISSUE_WIDTH],
    input  logic [1:0]          p_src_valid_i [wired_pkg::ISSUE_WIDTH],
    input  wired_pkg::rob_rid_t p_src_tag_i [wired_pkg::ISSUE_WIDTH][2],
    input  wired_pkg::word_t    p_src_data_i [wired_pkg::ISSUE_WIDTH][2],
    output logic                p_ready_o,
    input  logic [wired_pkg::CDB_PORTS-1:0] cdb_valid_i,
    input  wired_pkg::rob_rid_t cdb_rid_i [wired_pkg::CDB_PORTS],
    input  wired_pkg::word_t    cdb_data_i [wired_pkg::CDB_PORTS],
    input  logic [wired_pkg::ISSUE_WIDTH-1:0] cdb_ready_i,
    output logic [wired_pkg::ISSUE_WIDTH-1:0] cdb_valid_o,
    output wired_pkg::rob_rid_t cdb_rid_o [wired_pkg::ISSUE_WIDTH],
    output wired_pkg::word_t    cdb_data_o [wired_pkg::ISSUE_WIDTH]
);
    import wired_pkg::*;

    logic [ISSUE_WIDTH-1:0] iss_valid;
    rob_rid_t               iss_rid [ISSUE_WIDTH];
    word_t                  iss_res [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] fifo_full;
    logic                   fu_stall;

    // one full fifo holds both lanes, keeps them in step
    assign fu_stall = |fifo_full;

    wired_alu_iq wired_alu_iq_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .p_valid_i     (p_valid_i),
        .p_rid_i       (p_rid_i),
        .p_op_i        (p_op_i),
        .p_pc_i        (p_pc_i),
        .p_src_valid_i (p_src_valid_i),
        .p_src_tag_i   (p_src_tag_i),
        .p_src_data_i  (p_src_data_i),
        .p_ready_o     (p_ready_o),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_rid_i     (cdb_rid_i),
        .cdb_data_i    (cdb_data_i),
        .fu_stall_i    (fu_stall),
        .iss_valid_o   (iss_valid),
        .iss_rid_o     (iss_rid),
        .iss_res_o     (iss_res)
    );

    // one result fifo per cdb write port
    for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_fifo
        wired_cdb_fifo wired_cdb_fifo_i (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .push_i      (iss_valid[l]),
            .push_rid_i  (iss_rid[l]),
            .push_data_i (iss_res[l]),
            .pop_ready_i (cdb_ready_i[l]),
            .full_o      (fifo_full[l]),
            .valid_o     (cdb_valid_o[l]),
            .rid_o       (cdb_rid_o[l]),
            .data_o      (cdb_data_o[l])
        );
    end

endmodule

//--- tb_wired_alu_cluster.sv
`timescale 1ns/1ps

module tb_wired_alu_cluster;
    import wired_pkg::*;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 10;
    localparam int STIM_CYCLES  = 2000;
    localparam int DRAIN_CYCLES = 300;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + STIM_CYCLES + DRAIN_CYCLES + 20) * PERIOD;
    // dispatched rids live in 0..31 and external producers in 32..63
    localparam int NUM_RIDS     = 32;
    localparam int MAX_INFLIGHT = IQ_DEPTH + 2 * FIFO_DEPTH;
    // cdb stall window long enough to fill the fifos and the queue
    localparam int STALL_FROM   = 400;
    localparam int STALL_TO     = 520;

    logic                   clk;
    logic                   rst_n_i;
    logic                   flush_i;
    logic [ISSUE_WIDTH-1:0] p_valid_i;
    rob_rid_t               p_rid_i [ISSUE_WIDTH];
    alu_op_t                p_op_i [ISSUE_WIDTH];
    word_t                  p_pc_i [ISSUE_WIDTH];
    logic [1:0]             p_src_valid_i [ISSUE_WIDTH];
    rob_rid_t               p_src_tag_i [ISSUE_WIDTH][2];
    word_t                  p_src_data_i [ISSUE_WIDTH][2];
    logic                   p_ready_o;
    logic [CDB_PORTS-1:0]   cdb_valid_i;
    rob_rid_t               cdb_rid_i [CDB_PORTS];
    word_t                  cdb_data_i [CDB_PORTS];
    logic [ISSUE_WIDTH-1:0] cdb_ready_i;
    logic [ISSUE_WIDTH-1:0] cdb_valid_o;
    rob_rid_t               cdb_rid_o [ISSUE_WIDTH];
    word_t                  cdb_data_o [ISSUE_WIDTH];

    integer seed;

    // reference model indexed by rid
    bit    inflight [NUM_RIDS];
    word_t exp_res [NUM_RIDS];
    int    dep_tag [NUM_RIDS][2];
    bit    dep_wait [NUM_RIDS][2];
    // external producer values stay fixed while pending
    bit    ext_pending [2 * NUM_RIDS];
    word_t ext_val [2 * NUM_RIDS];

    int inflight_cnt;
    int err_cnt;
    int check_cnt;
    int retire_cnt;
    int flush_cnt;
    bit saw_full;
    bit flush_prev;

    // last cycle's output view for the stall check
    bit    prev_valid [ISSUE_WIDTH];
    bit    prev_ready [ISSUE_WIDTH];
    int    prev_rid [ISSUE_WIDTH];
    word_t prev_data [ISSUE_WIDTH];

    wired_alu_cluster wired_alu_cluster_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .p_valid_i     (p_valid_i),
        .p_rid_i       (p_rid_i),
        .p_op_i        (p_op_i),
        .p_pc_i        (p_pc_i),
        .p_src_valid_i (p_src_valid_i),
        .p_src_tag_i   (p_src_tag_i),
        .p_src_data_i  (p_src_data_i),
        .p_ready_o     (p_ready_o),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_rid_i     (cdb_rid_i),
        .cdb_data_i    (cdb_data_i),
        .cdb_ready_i   (cdb_ready_i),
        .cdb_valid_o   (cdb_valid_o),
        .cdb_rid_o     (cdb_rid_o),
        .cdb_data_o    (cdb_data_o)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // expected alu result straight from the op table
    function automatic word_t model_alu(input alu_op_t op, input word_t a, input word_t b,
                                        input word_t pc);
        word_t r;
        case (op)
            ALU_ADD:   r = a + b;
            ALU_SUB:   r = a - b;
            ALU_AND:   r = a & b;
            ALU_OR:    r = a | b;
            ALU_XOR:   r = a ^ b;
            ALU_SLL:   r = a << b[4:0];
            ALU_SRL:   r = a >> b[4:0];
            ALU_SRA:   r = word_t'($signed(a) >>> b[4:0]);
            ALU_SLT:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU:  r = (a < b) ? 32'd1 : 32'd0;
            ALU_PCADD: r = pc + b;
            default:   r = '0;
        endcase
        return r;
    endfunction

    // rotating scans return -1 when nothing is found
    function automatic int find_free_rid(input int start);
        int r;
        for (int i = 0; i < NUM_RIDS; i++) begin
            r = (start + i) % NUM_RIDS;
            if (!inflight[r]) begin
                return r;
            end
        end
        return -1;
    endfunction

    function automatic int find_pending(input int start);
        int e;
        for (int i = 0; i < NUM_RIDS; i++) begin
            e = NUM_RIDS + (start + i) % NUM_RIDS;
            if (ext_pending[e]) begin
                return e;
            end
        end
        return -1;
    endfunction

    task automatic check_outputs();
        int r;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            // payload must hold while valid waits for ready
            if (prev_valid[l] && !prev_ready[l] && !flush_prev) begin
                check_cnt++;
                if (!cdb_valid_o[l] || int'(cdb_rid_o[l]) != prev_rid[l] ||
                    cdb_data_o[l] != prev_data[l]) begin
                    err_cnt++;
                    $display("ERR %0t: lane %0d payload changed while stalled", $time, l);
                end
            end
            if (cdb_valid_o[l]) begin
                r = int'(cdb_rid_o[l]);
                check_cnt++;
                if (r >= NUM_RIDS || !inflight[r]) begin
                    err_cnt++;
                    $display("ERR %0t: lane %0d rid %0d is not in flight", $time, l, r);
                end else begin
                    if (cdb_data_o[l] != exp_res[r]) begin
                        err_cnt++;
                        $display("ERR %0t: lane %0d rid %0d data %h, expected %h",
                                 $time, l, r, cdb_data_o[l], exp_res[r]);
                    end
                    if (dep_wait[r][0] || dep_wait[r][1]) begin
                        err_cnt++;
                        $display("ERR %0t: rid %0d left before its broadcast", $time, r);
                    end
                    // handshake completes at the coming edge
                    if (cdb_ready_i[l]) begin
                        inflight[r] = 1'b0;
                        inflight_cnt--;
                        retire_cnt++;
                    end
                end
            end
            prev_valid[l] = cdb_valid_o[l];
            prev_ready[l] = cdb_ready_i[l];
            prev_rid[l]   = int'(cdb_rid_o[l]);
            prev_data[l]  = cdb_data_o[l];
        end
    endtask

    task automatic drive_dispatch(input int disp_pct);
        int      r;
        int      e;
        word_t   opnd [2];
        alu_op_t op;
        word_t   pc;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            // idle lanes still carry junk fields
            p_valid_i[l] = 1'b0;
            p_rid_i[l]   = rob_rid_t'(rand_below(2 * NUM_RIDS));
            p_op_i[l]    = alu_op_t'(rand_below(16));
            p_pc_i[l]    = $random(seed);
            r = find_free_rid(rand_below(NUM_RIDS));
            if (p_ready_o && r >= 0 && rand_below(100) < disp_pct) begin
                op = alu_op_t'(rand_below(16));
                pc = $random(seed);
                for (int k = 0; k < 2; k++) begin
                    if (rand_below(100) < 40) begin
                        // wait on an external producer and start a new one if idle
                        e = NUM_RIDS + rand_below(NUM_RIDS);
                        if (!ext_pending[e]) begin
                            ext_pending[e] = 1'b1;
                            ext_val[e]     = $random(seed);
                        end
                        opnd[k]             = ext_val[e];
                        p_src_valid_i[l][k] = 1'b0;
                        p_src_tag_i[l][k]   = rob_rid_t'(e);
                        p_src_data_i[l][k]  = $random(seed);
                        dep_tag[r][k]       = e;
                        dep_wait[r][k]      = 1'b1;
                    end else begin
                        opnd[k]             = $random(seed);
                        p_src_valid_i[l][k] = 1'b1;
                        p_src_tag_i[l][k]   = rob_rid_t'(rand_below(2 * NUM_RIDS));
                        p_src_data_i[l][k]  = opnd[k];
                        dep_wait[r][k]      = 1'b0;
                    end
                end
                p_valid_i[l] = 1'b1;
                p_rid_i[l]   = rob_rid_t'(r);
                p_op_i[l]    = op;
                p_pc_i[l]    = pc;
                // a dispatch in a flush cycle is dropped and never retires
                if (!flush_i) begin
                    exp_res[r]  = model_alu(op, opnd[0], opnd[1], pc);
                    inflight[r] = 1'b1;
                    inflight_cnt++;
                end
            end
        end
    endtask

    task automatic drive_broadcast(input int bc_pct);
        int e;
        for (int c = 0; c < CDB_PORTS; c++) begin
            // invalid slots show a live tag with wrong data
            cdb_valid_i[c] = 1'b0;
            cdb_rid_i[c]   = rob_rid_t'(NUM_RIDS + rand_below(NUM_RIDS));
            cdb_data_i[c]  = $random(seed);
            e = find_pending(rand_below(NUM_RIDS));
            if (e >= 0 && rand_below(100) < bc_pct) begin
                cdb_valid_i[c] = 1'b1;
                cdb_rid_i[c]   = rob_rid_t'(e);
                cdb_data_i[c]  = ext_val[e];
                ext_pending[e] = 1'b0;
                for (int r = 0; r < NUM_RIDS; r++) begin
                    for (int k = 0; k < 2; k++) begin
                        if (inflight[r] && dep_wait[r][k] && dep_tag[r][k] == e) begin
                            dep_wait[r][k] = 1'b0;
                        end
                    end
                end
            end
        end
    endtask

    // one cycle of stimulus and checks at the falling edge
    task automatic run_cycle(input int disp_pct, input int ready_pct, input int bc_pct,
                             input bit do_flush);
        if (flush_prev) begin
            check_cnt++;
            if (!p_ready_o) begin
                err_cnt++;
                $display("ERR %0t: p_ready_o low in the cycle after a flush", $time);
            end
        end
        if (!p_ready_o) begin
            saw_full = 1'b1;
        end
        flush_i = do_flush;
        // no cdb transfer in a flush cycle
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            cdb_ready_i[l] = !do_flush && (rand_below(100) < ready_pct);
        end
        check_outputs();
        if (do_flush) begin
            for (int r = 0; r < NUM_RIDS; r++) begin
                if (inflight[r]) begin
                    inflight[r] = 1'b0;
                    flush_cnt++;
                end
            end
            inflight_cnt = 0;
        end
        drive_dispatch(disp_pct);
        drive_broadcast(bc_pct);
        check_cnt++;
        if (inflight_cnt > MAX_INFLIGHT) begin
            err_cnt++;
            $display("ERR %0t: %0d instructions in flight, limit %0d",
                     $time, inflight_cnt, MAX_INFLIGHT);
        end
        flush_prev = do_flush;
    endtask

    initial begin
        int ready_pct;
        bit do_flush;
        seed        = 32'hca74b2af;
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        flush_i     = 1'b0;
        p_valid_i   = '0;
        cdb_valid_i = '0;
        cdb_ready_i = '0;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            p_rid_i[l]       = '0;
            p_op_i[l]        = '0;
            p_pc_i[l]        = '0;
            p_src_valid_i[l] = '0;
            for (int k = 0; k < 2; k++) begin
                p_src_tag_i[l][k]  = '0;
                p_src_data_i[l][k] = '0;
            end
            prev_valid[l] = 1'b0;
            prev_ready[l] = 1'b0;
            prev_rid[l]   = 0;
            prev_data[l]  = '0;
        end
        for (int c = 0; c < CDB_PORTS; c++) begin
            cdb_rid_i[c]  = '0;
            cdb_data_i[c] = '0;
        end
        for (int r = 0; r < 2 * NUM_RIDS; r++) begin
            ext_pending[r] = 1'b0;
            ext_val[r]     = '0;
        end
        for (int r = 0; r < NUM_RIDS; r++) begin
            inflight[r]    = 1'b0;
            exp_res[r]     = '0;
            dep_tag[r][0]  = 0;
            dep_tag[r][1]  = 0;
            dep_wait[r][0] = 1'b0;
            dep_wait[r][1] = 1'b0;
        end
        inflight_cnt = 0;
        err_cnt      = 0;
        check_cnt    = 0;
        retire_cnt   = 0;
        flush_cnt    = 0;
        saw_full     = 1'b0;
        flush_prev   = 1'b0;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;

        // idle state straight out of reset
        check_cnt++;
        if (!p_ready_o || cdb_valid_o != '0) begin
            err_cnt++;
            $display("ERR %0t: bad state after reset, p_ready_o %b cdb_valid_o %b",
                     $time, p_ready_o, cdb_valid_o);
        end

        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            @(negedge clk);
            ready_pct = (cyc >= STALL_FROM && cyc < STALL_TO) ? 0 : 70;
            // one fixed flush plus rare random ones
            do_flush  = (cyc == 1200) || (cyc > 50 && rand_below(150) == 0);
            run_cycle(80, ready_pct, 40, do_flush);
        end

        // drain with every producer broadcasting and the cdb always ready
        for (int d = 0; d < DRAIN_CYCLES && inflight_cnt > 0; d++) begin
            @(negedge clk);
            run_cycle(0, 100, 100, 1'b0);
        end

        for (int r = 0; r < NUM_RIDS; r++) begin
            if (inflight[r]) begin
                err_cnt++;
                $display("rid %0d was dispatched but never retired", r);
            end
        end
        if (!saw_full) begin
            err_cnt++;
            $display("p_ready_o never fell while the CDB outputs were stalled");
        end
        $display("checks %0d, retired %0d, flushed %0d, errors %0d",
                 check_cnt, retire_cnt, flush_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog covers stimulus plus drain plus a margin
    initial begin
        #(TIMEOUT_NS);
        $display("the run timed out before the tests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- build.f
wired_pkg.sv
wired_alu.sv
wired_iq_entry.sv
wired_cdb_fifo.sv
wired_alu_iq.sv
wired_alu_cluster.sv
tb_wired_alu_cluster.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_wired_alu_cluster
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
